/* logic/mpmc_cache.sv */
`timescale 1ns/1ns
`default_nettype none

module mpmc_cache (
	input  logic                     ch0clk,
	input  logic                     rst,
	input  logic                     rd_req,
	input  logic                     wr_req,
	input  logic                     ld_req,
	input  logic                     inv_req,
	input  mpmc_cache_pkg::rd_req_t  rd,
	input  mpmc_cache_pkg::wr_req_t  wr,
	input  mpmc_cache_pkg::ld_req_t  ld,
	input  mpmc_cache_pkg::inv_req_t inv,
	output logic                     rd_ack,
	output logic                     wr_ack,
	output logic                     ld_ack,
	output logic                     inv_ack,
	output mpmc_cache_pkg::rd_resp_t rd_resp,
	output mpmc_cache_pkg::wr_resp_t wr_resp
);
	import mpmc_cache_pkg::*;

	// ==============================
	// Controller to tag lookup
	// ==============================

	cache_index_t lk_index;
	cache_tag_t lk_tag;
	logic tag_we;
	logic valid_clr;
	cache_way_t tag_way;
	logic hit;
	cache_way_t hit_way;

	// ==============================
	// Controller to line storage
	// ==============================

	cache_index_t ram_rd_index;
	cache_way_t ram_rd_way;
	logic ram_we;
	cache_way_t ram_wr_way;
	cache_index_t ram_wr_index;
	cache_strb_t ram_strb;
	cache_line_t ram_wr_line;
	cache_line_t ram_line;

	// Sequencing, arbitration and the four handshakes
	mpmc_cache_ctrl u_ctrl (
		.ch0clk       (ch0clk),
		.rst          (rst),
		.rd_req       (rd_req),
		.wr_req       (wr_req),
		.ld_req       (ld_req),
		.inv_req      (inv_req),
		.rd           (rd),
		.wr           (wr),
		.ld           (ld),
		.inv          (inv),
		.rd_ack       (rd_ack),
		.wr_ack       (wr_ack),
		.ld_ack       (ld_ack),
		.inv_ack      (inv_ack),
		.rd_resp      (rd_resp),
		.wr_resp      (wr_resp),
		.lk_index     (lk_index),
		.lk_tag       (lk_tag),
		.tag_we       (tag_we),
		.valid_clr    (valid_clr),
		.tag_way      (tag_way),
		.hit          (hit),
		.hit_way      (hit_way),
		.ram_rd_index (ram_rd_index),
		.ram_rd_way   (ram_rd_way),
		.ram_we       (ram_we),
		.ram_wr_way   (ram_wr_way),
		.ram_wr_index (ram_wr_index),
		.ram_strb     (ram_strb),
		.ram_wr_line  (ram_wr_line),
		.ram_line     (ram_line)
	);

	mpmc_cache_tag_lookup u_tag_lookup (
		.ch0clk    (ch0clk),
		.rst       (rst),
		.lk_index  (lk_index),
		.lk_tag    (lk_tag),
		.tag_we    (tag_we),
		.valid_clr (valid_clr),
		.tag_way   (tag_way),
		.hit       (hit),
		.hit_way   (hit_way)
	);

	mpmc_cache_data_ram u_data_ram (
		.ch0clk       (ch0clk),
		.ram_rd_index (ram_rd_index),
		.ram_rd_way   (ram_rd_way),
		.ram_we       (ram_we),
		.ram_wr_way   (ram_wr_way),
		.ram_wr_index (ram_wr_index),
		.ram_strb     (ram_strb),
		.ram_wr_line  (ram_wr_line),
		.ram_line     (ram_line)
	);

endmodule

`default_nettype wire

/* logic/mpmc_cache_consts.svh */
`ifndef MPMC_CACHE_CONSTS_SVH
`define MPMC_CACHE_CONSTS_SVH

// ==============================
// Cache geometry
// ==============================

// Four ways of associativity
`define CACHE_WAYS 4

// Sets per way, one line per set in each way
`define CACHE_SETS 128

// Bytes in one cache line
`define CACHE_LINE_BYTES 32

// ==============================
// Address split
// ==============================

`define CACHE_ADDR_W 32    // Byte address width
`define CACHE_OFFSET_W 5   // Byte within the line
`define CACHE_INDEX_W 7    // Set index above the offset
`define CACHE_TAG_W 20     // Everything above the index

// Bits needed to name one way
`define CACHE_WAY_W 2

`endif

/* logic/mpmc_cache_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mpmc_cache_consts.svh"

module mpmc_cache_ctrl (
	input  logic                         ch0clk,
	input  logic                         rst,
	input  logic                         rd_req,
	input  logic                         wr_req,
	input  logic                         ld_req,
	input  logic                         inv_req,
	input  mpmc_cache_pkg::rd_req_t      rd,
	input  mpmc_cache_pkg::wr_req_t      wr,
	input  mpmc_cache_pkg::ld_req_t      ld,
	input  mpmc_cache_pkg::inv_req_t     inv,
	output logic                         rd_ack,
	output logic                         wr_ack,
	output logic                         ld_ack,
	output logic                         inv_ack,
	output mpmc_cache_pkg::rd_resp_t     rd_resp,
	output mpmc_cache_pkg::wr_resp_t     wr_resp,
	output mpmc_cache_pkg::cache_index_t lk_index,
	output mpmc_cache_pkg::cache_tag_t   lk_tag,
	output logic                         tag_we,
	output logic                         valid_clr,
	output mpmc_cache_pkg::cache_way_t   tag_way,
	input  logic                         hit,
	input  mpmc_cache_pkg::cache_way_t   hit_way,
	output mpmc_cache_pkg::cache_index_t ram_rd_index,
	output mpmc_cache_pkg::cache_way_t   ram_rd_way,
	output logic                         ram_we,
	output mpmc_cache_pkg::cache_way_t   ram_wr_way,
	output mpmc_cache_pkg::cache_index_t ram_wr_index,
	output mpmc_cache_pkg::cache_strb_t  ram_strb,
	output mpmc_cache_pkg::cache_line_t  ram_wr_line,
	input  mpmc_cache_pkg::cache_line_t  ram_line
);
	import mpmc_cache_pkg::*;

	ctrl_state_t state;
	logic op_ld, op_inv, op_wr, op_rd;      // One-hot kind of the request in service
	logic grant_ld, grant_inv, grant_wr, grant_rd;
	logic start;                            // Accept a new request this edge
	logic acked;                            // Ack of the current request is already up
	logic cur_req;                          // Req line of the port in service
	logic in_update;

	cache_addr_t addr_q;                    // Latched request fields
	cache_way_t way_q;
	cache_strb_t strb_q;
	cache_line_t line_q;
	logic hit_q;                            // Lookup result kept for the response
	cache_way_t hit_way_q;
	cache_index_t cur_index;
	cache_tag_t cur_tag;

	// ==============================
	// Arbitration
	// ==============================

	// Fixed priority ld, inv, wr, rd and losers simply keep req up
	assign grant_ld = ld_req;
	assign grant_inv = inv_req && !ld_req;
	assign grant_wr = wr_req && !ld_req && !inv_req;
	assign grant_rd = rd_req && !ld_req && !inv_req && !wr_req;
	assign start = (state == IDLE) && (ld_req || inv_req || wr_req || rd_req);

	assign acked = rd_ack || wr_ack || ld_ack || inv_ack;
	assign cur_req = (op_ld && ld_req) || (op_inv && inv_req) ||
		(op_wr && wr_req) || (op_rd && rd_req);

	// ==============================
	// Sequencer
	// ==============================

	always_ff @(posedge ch0clk) begin
		if (rst) begin
			state <= IDLE;
			{op_ld, op_inv, op_wr, op_rd} <= 4'b0000;
			{rd_ack, wr_ack, ld_ack, inv_ack} <= 4'b0000;
		end else begin
			case (state)
				IDLE: begin
					{rd_ack, wr_ack, ld_ack, inv_ack} <= 4'b0000;   // Finish the previous handshake
					if (start) begin
						{op_ld, op_inv, op_wr, op_rd} <= {grant_ld, grant_inv, grant_wr, grant_rd};
						// Loads and invalidates need no lookup
						state <= (grant_ld || grant_inv) ? UPDATE : LOOKUP;
					end
				end
				LOOKUP: state <= UPDATE;    // Tag RAM read in flight
				UPDATE: state <= RESPOND;   // Writes and the data read happen at this edge
				RESPOND: begin
					if (!acked) begin
						rd_ack <= op_rd;
						wr_ack <= op_wr;
						ld_ack <= op_ld;
						inv_ack <= op_inv;
					end else if (!cur_req) begin
						state <= IDLE;          // Ack drops on the following edge
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Request payload is captured only when a request is accepted
	always_ff @(posedge ch0clk) begin
		if (start) begin
			if (grant_ld) begin
				addr_q <= ld.addr;
				way_q <= ld.way;
				line_q <= ld.line;
			end else if (grant_inv) begin
				addr_q <= inv.addr;
				way_q <= inv.way;
			end else if (grant_wr) begin
				addr_q <= wr.addr;
				strb_q <= wr.strb;
				line_q <= wr.data;
			end else begin
				addr_q <= rd.addr;
			end
		end
	end

	// ==============================
	// Response registers
	// ==============================

	always_ff @(posedge ch0clk) begin
		if (in_update) begin
			hit_q <= hit;           // Compare result is stable during UPDATE
			hit_way_q <= hit_way;
		end
		if (state == RESPOND && !acked) begin
			if (op_rd) begin
				rd_resp.hit <= hit_q;
				rd_resp.way <= hit_way_q;
				rd_resp.line <= hit_q ? ram_line : '0;   // No stale data on a miss
			end
			if (op_wr)
				wr_resp.hit <= hit_q;
		end
	end

	// ==============================
	// Datapath controls
	// ==============================

	assign in_update = (state == UPDATE);
	assign cur_index = addr_q[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
	assign cur_tag = addr_q[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];

	assign lk_index = cur_index;
	assign lk_tag = cur_tag;
	assign tag_we = in_update && op_ld;         // Load stores the tag and sets valid
	assign valid_clr = in_update && op_inv;     // Invalidate touches only the valid bit
	assign tag_way = way_q;

	assign ram_rd_index = cur_index;
	assign ram_rd_way = hit_way;                // Read the way that matched
	assign ram_we = in_update && (op_ld || (op_wr && hit));
	assign ram_wr_way = op_ld ? way_q : hit_way;
	assign ram_wr_index = cur_index;
	assign ram_strb = op_ld ? {`CACHE_LINE_BYTES{1'b1}} : strb_q;
	assign ram_wr_line = line_q;

endmodule

`default_nettype wire

/* logic/mpmc_cache_data_ram.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mpmc_cache_consts.svh"

module mpmc_cache_data_ram (
	input  logic                         ch0clk,
	input  mpmc_cache_pkg::cache_index_t ram_rd_index,   // Set to read
	input  mpmc_cache_pkg::cache_way_t   ram_rd_way,     // Way whose line comes back
	input  logic                         ram_we,
	input  mpmc_cache_pkg::cache_way_t   ram_wr_way,
	input  mpmc_cache_pkg::cache_index_t ram_wr_index,
	input  mpmc_cache_pkg::cache_strb_t  ram_strb,       // Byte enables, all ones for a load
	input  mpmc_cache_pkg::cache_line_t  ram_wr_line,    // Bytes already in line position
	output mpmc_cache_pkg::cache_line_t  ram_line        // Line read one cycle earlier
);
	import mpmc_cache_pkg::*;

	cache_line_t way_line [`CACHE_WAYS];    // Registered read data of every way
	cache_way_t rd_way_q;                   // Way select delayed with the read

	// ==============================
	// Line storage, one RAM per way
	// ==============================

	for (genvar w = 0; w < `CACHE_WAYS; w++) begin : g_way
		cache_line_t lines [`CACHE_SETS];   // Inferred byte-writable RAM
		logic way_we;

		assign way_we = ram_we && (ram_wr_way == cache_way_t'(w));

		always_ff @(posedge ch0clk) begin
			// Only the strobed bytes change, which merges a write hit into the old line
			for (int b = 0; b < `CACHE_LINE_BYTES; b++) begin
				if (way_we && ram_strb[b])
					lines[ram_wr_index][b*8 +: 8] <= ram_wr_line[b*8 +: 8];
			end
			way_line[w] <= lines[ram_rd_index];   // Read returns the old contents on a collision
		end
	end

	// ==============================
	// Way select
	// ==============================

	// Every way reads its set in parallel and the way number follows one cycle later
	always_ff @(posedge ch0clk) begin
		rd_way_q <= ram_rd_way;
	end

	assign ram_line = way_line[rd_way_q];

endmodule

`default_nettype wire

/* logic/mpmc_cache_pkg.sv */
`default_nettype none

`include "mpmc_cache_consts.svh"

package mpmc_cache_pkg;

	// ==============================
	// Vector types
	// ==============================

	typedef logic [`CACHE_ADDR_W-1:0] cache_addr_t;         // Byte address
	typedef logic [`CACHE_INDEX_W-1:0] cache_index_t;       // Set index
	typedef logic [`CACHE_TAG_W-1:0] cache_tag_t;           // Tag kept per way and set
	typedef logic [`CACHE_WAY_W-1:0] cache_way_t;           // Way number
	typedef logic [`CACHE_LINE_BYTES*8-1:0] cache_line_t;   // Whole line, byte 0 in the low bits
	typedef logic [`CACHE_LINE_BYTES-1:0] cache_strb_t;     // One enable per line byte

	// ==============================
	// Request and response bundles
	// ==============================

	typedef struct packed {
		cache_addr_t addr;
	} rd_req_t;

	typedef struct packed {
		logic hit;            // Line was present
		cache_way_t way;      // Way that held it
		cache_line_t line;    // Line contents, zero on a miss
	} rd_resp_t;

	// Write data sits at its byte position inside the line
	typedef struct packed {
		cache_addr_t addr;
		cache_strb_t strb;
		cache_line_t data;
	} wr_req_t;

	typedef struct packed {
		logic hit;
	} wr_resp_t;

	typedef struct packed {
		cache_addr_t addr;
		cache_way_t way;      // Way picked by the requester
		cache_line_t line;
	} ld_req_t;

	typedef struct packed {
		cache_addr_t addr;
		cache_way_t way;
	} inv_req_t;

	// Sequencer states of the controller
	typedef enum logic [1:0] {
		IDLE,
		LOOKUP,
		UPDATE,
		RESPOND
	} ctrl_state_t;

endpackage

`default_nettype wire

/* logic/mpmc_cache_tag_lookup.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mpmc_cache_consts.svh"

module mpmc_cache_tag_lookup (
	input  logic                         ch0clk,
	input  logic                         rst,
	input  mpmc_cache_pkg::cache_index_t lk_index,   // Set to look up or to write
	input  mpmc_cache_pkg::cache_tag_t   lk_tag,     // Tag to compare or to store
	input  logic                         tag_we,     // Store lk_tag and set the valid bit
	input  logic                         valid_clr,  // Clear the valid bit
	input  mpmc_cache_pkg::cache_way_t   tag_way,    // Way targeted by tag_we and valid_clr
	output logic                         hit,
	output mpmc_cache_pkg::cache_way_t   hit_way
);
	import mpmc_cache_pkg::*;

	cache_tag_t cmp_tag_q;                  // Compare tag, aligned with the tag reads
	logic [`CACHE_WAYS-1:0] way_match;      // Per way hit after the read stage

	// ==============================
	// Tag and valid storage per way
	// ==============================

	for (genvar w = 0; w < `CACHE_WAYS; w++) begin : g_way
		cache_tag_t tags [`CACHE_SETS];       // Inferred tag RAM
		logic [`CACHE_SETS-1:0] valid_bits;   // Kept in flops so reset can clear them
		cache_tag_t tag_rd_q;                 // Registered tag of the looked up set
		logic valid_rd_q;                     // Registered valid bit of the same set
		logic way_sel;

		assign way_sel = (tag_way == cache_way_t'(w));

		// Tag write and synchronous read of the selected set
		always_ff @(posedge ch0clk) begin
			if (tag_we && way_sel)
				tags[lk_index] <= lk_tag;
			tag_rd_q <= tags[lk_index];     // Old tag is returned on a write collision
		end

		always_ff @(posedge ch0clk) begin
			if (rst) begin
				valid_bits <= '0;            // Whole cache is empty out of reset
				valid_rd_q <= 1'b0;
			end else begin
				if (tag_we && way_sel)
					valid_bits[lk_index] <= 1'b1;    // A load makes the line live
				else if (valid_clr && way_sel)
					valid_bits[lk_index] <= 1'b0;    // Invalidate drops it
				valid_rd_q <= valid_bits[lk_index];
			end
		end

		// A way hits only when its line is valid and the stored tag matches
		assign way_match[w] = valid_rd_q && (tag_rd_q == cmp_tag_q);
	end

	// ==============================
	// Compare stage
	// ==============================

	// The compare tag is delayed to line up with the registered RAM read
	always_ff @(posedge ch0clk) begin
		cmp_tag_q <= lk_tag;
	end

	assign hit = |way_match;

	// Lowest matching way wins, way 0 when nothing matches
	always_comb begin
		hit_way = '0;
		for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
			if (way_match[w])
				hit_way = cache_way_t'(w);
		end
	end

endmodule

`default_nettype wire

/* mpmc_cache.f */
+incdir+logic
logic/mpmc_cache_pkg.sv
logic/mpmc_cache_tag_lookup.sv
logic/mpmc_cache_data_ram.sv
logic/mpmc_cache_ctrl.sv
logic/mpmc_cache.sv
tests/mpmc_cache_tb.sv

/* run_sim.sh */
#!/bin/bash
# Build and run the cache testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f mpmc_cache.f --top-module mpmc_cache_tb \
	-o mpmc_cache_sim > build.log 2>&1 \
	&& ./obj_dir/mpmc_cache_sim > sim.log 2>&1 \
	|| { echo "Build or simulation failed, see build.log and sim.log"; exit 1; }

grep -q "RESULT: PASS" sim.log \
	&& { echo "Simulation passed"; exit 0; } \
	|| { echo "Simulation failed, see sim.log"; exit 1; }

/* tests/mpmc_cache_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mpmc_cache_consts.svh"

module mpmc_cache_tb;
	import mpmc_cache_pkg::*;

	localparam int op_budget = 64;          // Handshakes issued by all tests with some margin
	localparam int cycles_per_op = 12;      // Longest handshake is about seven cycles
	localparam int watchdog_ns = (op_budget * cycles_per_op + 20) * 10;

	logic ch0clk;
	logic rst;
	logic rd_req, wr_req, ld_req, inv_req;
	rd_req_t rd;
	wr_req_t wr;
	ld_req_t ld;
	inv_req_t inv;
	logic rd_ack, wr_ack, ld_ack, inv_ack;
	rd_resp_t rd_resp;
	wr_resp_t wr_resp;

	int seed = 32'h0d57a67f;
	int checks = 0;
	int errors = 0;

	// Reference model of the cache contents
	logic model_valid [`CACHE_WAYS][`CACHE_SETS];
	cache_tag_t model_tag [`CACHE_WAYS][`CACHE_SETS];
	cache_line_t model_line [`CACHE_WAYS][`CACHE_SETS];
	cache_addr_t loaded_addr [8];           // Addresses loaded by the load test

	mpmc_cache u_dut (
		.ch0clk  (ch0clk),
		.rst     (rst),
		.rd_req  (rd_req),
		.wr_req  (wr_req),
		.ld_req  (ld_req),
		.inv_req (inv_req),
		.rd      (rd),
		.wr      (wr),
		.ld      (ld),
		.inv     (inv),
		.rd_ack  (rd_ack),
		.wr_ack  (wr_ack),
		.ld_ack  (ld_ack),
		.inv_ack (inv_ack),
		.rd_resp (rd_resp),
		.wr_resp (wr_resp)
	);

	initial begin
		ch0clk = 1'b0;
		forever #5 ch0clk = ~ch0clk;   // 100 MHz
	end

	// Ends a run that stops making progress
	initial begin
		#(watchdog_ns);
		$display("Watchdog timeout: the tests did not finish within %0d ns", watchdog_ns);
		$display("RESULT: FAIL");
		$finish;
	end

	// ==============================
	// Model and stimulus helpers
	// ==============================

	function automatic logic [31:0] rand32();
		return $random(seed);
	endfunction

	function automatic cache_line_t rand_line();
		cache_line_t l;
		for (int i = 0; i < `CACHE_LINE_BYTES / 4; i++)
			l[i*32 +: 32] = rand32();   // One 32-bit word at a time
		return l;
	endfunction

	function automatic cache_index_t index_of(input cache_addr_t a);
		return a[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
	endfunction

	function automatic cache_tag_t tag_of(input cache_addr_t a);
		return a[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
	endfunction

	// The lowest valid way with a matching tag gives the expected read response
	function automatic rd_resp_t model_read(input cache_addr_t a);
		rd_resp_t r;
		cache_way_t wy;
		r = '0;
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			wy = cache_way_t'(w);
			if (!r.hit && model_valid[wy][index_of(a)] &&
				model_tag[wy][index_of(a)] == tag_of(a)) begin
				r.hit = 1'b1;
				r.way = wy;
				r.line = model_line[wy][index_of(a)];
			end
		end
		return r;
	endfunction

	// A write merges strobed bytes on a hit and does nothing on a miss
	task automatic model_write(input cache_addr_t a, input cache_strb_t s, input cache_line_t d);
		rd_resp_t r;
		r = model_read(a);
		if (r.hit) begin
			for (int b = 0; b < `CACHE_LINE_BYTES; b++)
				if (s[b])
					r.line[b*8 +: 8] = d[b*8 +: 8];
			model_line[r.way][index_of(a)] = r.line;
		end
	endtask

	// ==============================
	// Compare tasks
	// ==============================

	task automatic check_rd(input rd_resp_t got, input rd_resp_t exp, input string what);
		checks++;
		if (got.hit !== exp.hit) begin
			errors++;
			$display("mismatch at %0t: %s read hit %0b, expected %0b",
				$time, what, got.hit, exp.hit);
		end else if (exp.hit && (got.way !== exp.way || got.line !== exp.line)) begin
			errors++;   // Way and line only mean something on a hit
			$display("mismatch at %0t: %s read way %0d line %h, expected way %0d line %h",
				$time, what, got.way, got.line, exp.way, exp.line);
		end
	endtask

	task automatic check_wr(input wr_resp_t got, input wr_resp_t exp, input string what);
		checks++;
		if (got.hit !== exp.hit) begin
			errors++;
			$display("mismatch at %0t: %s write hit %0b, expected %0b",
				$time, what, got.hit, exp.hit);
		end
	endtask

	// ==============================
	// Four-phase handshakes
	// ==============================

	// Each task starts and ends on a falling edge with its ack low
	task automatic do_read(input cache_addr_t a, output rd_resp_t resp);
		rd.addr = a;
		rd_req = 1'b1;
		while (rd_ack !== 1'b1) @(negedge ch0clk);
		resp = rd_resp;                        // Held while ack is high
		rd_req = 1'b0;
		while (rd_ack !== 1'b0) @(negedge ch0clk);
	endtask

	task automatic do_write(input cache_addr_t a, input cache_strb_t s, input cache_line_t d,
		output wr_resp_t resp);
		wr.addr = a;
		wr.strb = s;
		wr.data = d;
		wr_req = 1'b1;
		while (wr_ack !== 1'b1) @(negedge ch0clk);
		resp = wr_resp;
		wr_req = 1'b0;
		while (wr_ack !== 1'b0) @(negedge ch0clk);
		model_write(a, s, d);
	endtask

	task automatic do_load(input cache_addr_t a, input cache_way_t w, input cache_line_t l);
		ld.addr = a;
		ld.way = w;
		ld.line = l;
		ld_req = 1'b1;
		while (ld_ack !== 1'b1) @(negedge ch0clk);
		ld_req = 1'b0;
		while (ld_ack !== 1'b0) @(negedge ch0clk);
		model_valid[w][index_of(a)] = 1'b1;
		model_tag[w][index_of(a)] = tag_of(a);
		model_line[w][index_of(a)] = l;
	endtask

	task automatic do_inv(input cache_addr_t a, input cache_way_t w);
		inv.addr = a;
		inv.way = w;
		inv_req = 1'b1;
		while (inv_ack !== 1'b1) @(negedge ch0clk);
		inv_req = 1'b0;
		while (inv_ack !== 1'b0) @(negedge ch0clk);
		model_valid[w][index_of(a)] = 1'b0;
	endtask

	task automatic read_and_check(input cache_addr_t a, input string what);
		rd_resp_t r;
		do_read(a, r);
		check_rd(r, model_read(a), what);
	endtask

	task automatic report_test(input string name, input int errors_before);
		$display("test %s done with %0d errors", name, errors - errors_before);
	endtask

	// ==============================
	// Directed tests
	// ==============================

	task automatic reads_after_reset();
		int e0;
		e0 = errors;
		for (int i = 0; i < 8; i++)
			read_and_check(rand32(), "empty cache");   // Model is empty so every read misses
		report_test("reads_after_reset", e0);
	endtask

	task automatic load_then_read();
		int e0;
		e0 = errors;
		for (int i = 0; i < 8; i++) begin
			loaded_addr[i] = rand32();
			do_load(loaded_addr[i], cache_way_t'(rand32() & 3), rand_line());
		end
		for (int i = 0; i < 8; i++)
			read_and_check(loaded_addr[i], "loaded address");
		for (int i = 0; i < 8; i++)
			read_and_check(loaded_addr[i] ^ 32'h8000_0000, "other tag");   // Top tag bit flipped
		report_test("load_then_read", e0);
	endtask

	task automatic write_hit_and_miss();
		int e0;
		cache_addr_t a;
		cache_strb_t s;
		wr_resp_t r;
		wr_resp_t exp;
		rd_resp_t m;
		e0 = errors;
		a = loaded_addr[7];                 // The last load is still present
		s = rand32() & 32'h0f0f_33cc;       // Partial strobe
		m = model_read(a);
		exp.hit = m.hit;
		do_write(a, s, rand_line(), r);
		check_wr(r, exp, "write to loaded line");
		read_and_check(a, "merged line");
		m = model_read(a ^ 32'h8000_0000);
		exp.hit = m.hit;
		do_write(a ^ 32'h8000_0000, '1, rand_line(), r);
		check_wr(r, exp, "write to unloaded tag");
		read_and_check(a, "line after write miss");
		read_and_check(a ^ 32'h8000_0000, "unloaded tag after write miss");
		report_test("write_hit_and_miss", e0);
	endtask

	task automatic fill_one_set();
		int e0;
		cache_tag_t base;
		e0 = errors;
		base = tag_of(rand32());
		for (int w = 0; w < `CACHE_WAYS; w++)
			do_load({base + cache_tag_t'(w), 7'h2a, 5'h00}, cache_way_t'(w), rand_line());
		for (int w = 0; w < `CACHE_WAYS; w++)
			read_and_check({base + cache_tag_t'(w), 7'h2a, 5'h04}, "tag in its own way");
		report_test("fill_one_set", e0);
	endtask

	task automatic invalidate_way();
		int e0;
		cache_tag_t base;
		e0 = errors;
		base = model_tag[0][7'h2a];         // Set filled by the previous test
		do_inv({base + cache_tag_t'(1), 7'h2a, 5'h00}, 2'd1);
		for (int w = 0; w < `CACHE_WAYS; w++)
			read_and_check({base + cache_tag_t'(w), 7'h2a, 5'h10}, "after invalidate of way 1");
		report_test("invalidate_way", e0);
	endtask

	task automatic concurrent_requests();
		int e0;
		cache_addr_t a;
		rd_resp_t r;
		e0 = errors;
		a = {tag_of(rand32()), 7'h11, 5'h08};
		ld.addr = a;
		ld.way = 2'd3;
		ld.line = rand_line();
		rd.addr = a;
		ld_req = 1'b1;                      // Both requests rise on the same edge
		rd_req = 1'b1;
		while (ld_ack !== 1'b1) begin
			@(negedge ch0clk);
			if (rd_ack === 1'b1) begin
				errors++;
				$display("Read was served before the pending load at %0t", $time);
			end
		end
		ld_req = 1'b0;
		while (ld_ack !== 1'b0) @(negedge ch0clk);
		model_valid[3][7'h11] = 1'b1;
		model_tag[3][7'h11] = tag_of(a);
		model_line[3][7'h11] = ld.line;
		while (rd_ack !== 1'b1) @(negedge ch0clk);   // Read waited and is served now
		r = rd_resp;
		rd_req = 1'b0;
		while (rd_ack !== 1'b0) @(negedge ch0clk);
		check_rd(r, model_read(a), "read behind load");
		report_test("concurrent_requests", e0);
	endtask

	// ==============================
	// Main sequence
	// ==============================

	initial begin
		rst = 1'b1;
		{rd_req, wr_req, ld_req, inv_req} = 4'b0000;
		rd = '0;
		wr = '0;
		ld = '0;
		inv = '0;
		for (int w = 0; w < `CACHE_WAYS; w++)
			for (int s = 0; s < `CACHE_SETS; s++)
				model_valid[cache_way_t'(w)][cache_index_t'(s)] = 1'b0;
		repeat (5) @(negedge ch0clk);
		rst = 1'b0;
		@(negedge ch0clk);
		reads_after_reset();
		load_then_read();
		write_hit_and_miss();
		fill_one_set();
		invalidate_way();
		concurrent_requests();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
